//--- hdl/axil_rd_pkg.sv
// widths, response codes and channel structs for the AXI4 to AXI4-Lite read bridge
package axil_rd_pkg;

    localparam int addr_w      = 32;
    localparam int axi_data_w  = 64;
    localparam int axil_data_w = 32;
    localparam int id_w        = 4;

    // size codes of a full beat on each side
    localparam logic [2:0] axi_size_max = 3'd3;
    localparam logic [2:0] axil_size    = 3'd2;

    // Lite words per wide word
    localparam int lane_count = axi_data_w / axil_data_w;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef logic [addr_w-1:0] addr_t;

    // AXI4 read address
    typedef struct packed {
        logic [id_w-1:0] id;
        addr_t           addr;
        logic [7:0]      len;
        logic [2:0]      size;
        logic [2:0]      prot;
    } axi_ar_t;

    // AXI4-Lite read address
    typedef struct packed {
        addr_t      addr;
        logic [2:0] prot;
    } axil_ar_t;

    // AXI4 read data
    typedef struct packed {
        logic [id_w-1:0]       id;
        logic [axi_data_w-1:0] data;
        logic [1:0]            resp;
        logic                  last;
    } axi_r_t;

    // AXI4-Lite read data
    typedef struct packed {
        logic [axil_data_w-1:0] data;
        logic [1:0]             resp;
    } axil_r_t;

    // where the Lite read in flight lands in the wide beat
    typedef struct packed {
        logic lane;
        logic beat_end;
        logic burst_end;
    } beat_desc_t;

endpackage

//--- hdl/rd_burst_ctrl.sv
// burst controller: AXI AR acceptance, beat and Lite read counting, Lite AR generation
module rd_burst_ctrl (
    input  logic                         clk,
    input  logic                         rst,
    input  axil_rd_pkg::axi_ar_t         s_ar,
    input  logic                         s_arvalid,
    output logic                         s_arready,
    output axil_rd_pkg::axil_ar_t        m_ar,
    output logic                         m_arvalid,
    input  logic                         m_arready,
    input  logic                         word_taken,
    input  logic                         idle_ok,
    output axil_rd_pkg::beat_desc_t      desc,
    output logic [axil_rd_pkg::id_w-1:0] id
);

    typedef enum logic {
        st_idle,
        st_data
    } state_t;

    state_t state;

    // current wide beat address and beats left after it
    axil_rd_pkg::addr_t beat_addr;
    logic [7:0]         beat_cnt;
    // Lite reads left in the current beat after the one in flight
    logic               rd_cnt;
    logic [2:0]         size_q;

    logic               ar_fire;
    axil_rd_pkg::addr_t size_mask;
    axil_rd_pkg::addr_t next_beat_addr;

    function automatic axil_rd_pkg::addr_t lite_align(input axil_rd_pkg::addr_t a);
        return a & (~axil_rd_pkg::addr_t'(0) << axil_rd_pkg::axil_size);
    endfunction

    // a full-width beat starting in the lower lane also needs the upper lane
    function automatic logic extra_read(input axil_rd_pkg::addr_t a, input logic [2:0] size);
        return (size == axil_rd_pkg::axi_size_max) && !a[axil_rd_pkg::axil_size];
    endfunction

    assign ar_fire = s_arvalid && s_arready;

    // later beats are aligned to the transfer size
    assign size_mask      = ~axil_rd_pkg::addr_t'(0) << size_q;
    assign next_beat_addr = (beat_addr + (axil_rd_pkg::addr_t'(1) << size_q)) & size_mask;

    assign desc.lane      = m_ar.addr[axil_rd_pkg::axil_size];
    assign desc.beat_end  = !rd_cnt;
    assign desc.burst_end = !rd_cnt && (beat_cnt == 8'd0);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= st_idle;
            s_arready <= 1'b0;
            m_arvalid <= 1'b0;
        end else begin
            if (m_arready) begin
                m_arvalid <= 1'b0;
            end

            case (state)
                st_idle: begin
                    // wait for the last beat to leave before taking a new burst
                    s_arready <= idle_ok && !m_arvalid && !ar_fire;
                    if (ar_fire) begin
                        m_arvalid <= 1'b1;
                        state     <= st_data;
                    end
                end
                st_data: begin
                    s_arready <= 1'b0;
                    if (word_taken) begin
                        if (desc.burst_end) begin
                            state <= st_idle;
                        end else begin
                            m_arvalid <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            id         <= s_ar.id;
            size_q     <= s_ar.size;
            beat_addr  <= s_ar.addr;
            beat_cnt   <= s_ar.len;
            rd_cnt     <= extra_read(s_ar.addr, s_ar.size);
            m_ar.addr  <= lite_align(s_ar.addr);
            m_ar.prot  <= s_ar.prot;
        end else if (word_taken && !desc.burst_end) begin
            if (rd_cnt) begin
                // upper lane of the same wide beat
                rd_cnt    <= 1'b0;
                m_ar.addr <= m_ar.addr + (axil_rd_pkg::addr_t'(1) << axil_rd_pkg::axil_size);
            end else begin
                beat_addr <= next_beat_addr;
                beat_cnt  <= beat_cnt - 8'd1;
                rd_cnt    <= extra_read(next_beat_addr, size_q);
                m_ar.addr <= lite_align(next_beat_addr);
            end
        end
    end

endmodule

//--- hdl/rd_lane_merge.sv
// lane merger: Lite read data into wide beats, sticky error response, AXI R channel
module rd_lane_merge (
    input  logic                         clk,
    input  logic                         rst,
    input  axil_rd_pkg::axil_r_t         m_r,
    input  logic                         m_rvalid,
    output logic                         m_rready,
    input  logic                         m_arvalid,
    input  axil_rd_pkg::beat_desc_t      desc,
    input  logic [axil_rd_pkg::id_w-1:0] id,
    output axil_rd_pkg::axi_r_t          s_r,
    output logic                         s_rvalid,
    input  logic                         s_rready,
    output logic                         word_taken,
    output logic                         idle_ok
);

    // wide beat being collected, one Lite word per lane
    logic [axil_rd_pkg::lane_count-1:0][axil_rd_pkg::axil_data_w-1:0] data_q;
    logic [axil_rd_pkg::lane_count-1:0][axil_rd_pkg::axil_data_w-1:0] beat_data;

    logic [1:0] resp_q;
    logic [1:0] beat_resp;

    // a Lite address was issued and its data has not come back yet
    logic rd_pend;

    // data is taken only once the address is accepted and the R slot is free
    assign m_rready   = rd_pend && !m_arvalid && !s_rvalid;
    assign word_taken = m_rvalid && m_rready;

    // no beat left waiting at s_r after this edge
    assign idle_ok = !s_rvalid || s_rready;

    always_comb begin
        beat_data            = data_q;
        beat_data[desc.lane] = m_r.data;
    end

    // an earlier error in the beat survives a later okay word
    assign beat_resp = (m_r.resp != axil_rd_pkg::resp_okay) ? m_r.resp : resp_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pend <= 1'b0;
        end else if (m_arvalid) begin
            rd_pend <= 1'b1;
        end else if (word_taken) begin
            rd_pend <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_q <= axil_rd_pkg::resp_okay;
        end else if (word_taken) begin
            if (desc.beat_end) begin
                // next beat starts clean
                resp_q <= axil_rd_pkg::resp_okay;
            end else begin
                resp_q <= beat_resp;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_rvalid <= 1'b0;
        end else if (word_taken && desc.beat_end) begin
            s_rvalid <= 1'b1;
        end else if (s_rready) begin
            s_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (word_taken) begin
            data_q[desc.lane] <= m_r.data;
        end
        // s_r is only reloaded while s_rvalid is low, so it holds under back-pressure
        if (word_taken && desc.beat_end) begin
            s_r.id   <= id;
            s_r.data <= beat_data;
            s_r.resp <= beat_resp;
            s_r.last <= desc.burst_end;
        end
    end

endmodule

//--- hdl/axi_axil_rd_bridge.sv
// top level of the AXI4 to AXI4-Lite read bridge: burst controller and lane merger
module axi_axil_rd_bridge (
    input  logic                  clk,
    input  logic                  rst,

    // AXI4 read slave port, 64 bit
    input  axil_rd_pkg::axi_ar_t  s_ar,
    input  logic                  s_arvalid,
    output logic                  s_arready,
    output axil_rd_pkg::axi_r_t   s_r,
    output logic                  s_rvalid,
    input  logic                  s_rready,

    // AXI4-Lite read master port, 32 bit
    output axil_rd_pkg::axil_ar_t m_ar,
    output logic                  m_arvalid,
    input  logic                  m_arready,
    input  axil_rd_pkg::axil_r_t  m_r,
    input  logic                  m_rvalid,
    output logic                  m_rready
);

    axil_rd_pkg::beat_desc_t      desc;
    logic [axil_rd_pkg::id_w-1:0] id;
    logic                         word_taken;
    logic                         idle_ok;

    rd_burst_ctrl rd_burst_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .s_ar       (s_ar),
        .s_arvalid  (s_arvalid),
        .s_arready  (s_arready),
        .m_ar       (m_ar),
        .m_arvalid  (m_arvalid),
        .m_arready  (m_arready),
        .word_taken (word_taken),
        .idle_ok    (idle_ok),
        .desc       (desc),
        .id         (id)
    );

    // merger sees m_arvalid to know when the Lite address has gone out
    rd_lane_merge rd_lane_merge_inst (
        .clk        (clk),
        .rst        (rst),
        .m_r        (m_r),
        .m_rvalid   (m_rvalid),
        .m_rready   (m_rready),
        .m_arvalid  (m_arvalid),
        .desc       (desc),
        .id         (id),
        .s_r        (s_r),
        .s_rvalid   (s_rvalid),
        .s_rready   (s_rready),
        .word_taken (word_taken),
        .idle_ok    (idle_ok)
    );

endmodule

//--- tests/axil_slave_model.sv
// AXI4-Lite read slave model: address-derived data, SLVERR window, stall inputs for delays
module axil_slave_model (
    input  logic                  clk,
    input  logic                  rst,
    input  axil_rd_pkg::axil_ar_t m_ar,
    input  logic                  m_arvalid,
    output logic                  m_arready,
    output axil_rd_pkg::axil_r_t  m_r,
    output logic                  m_rvalid,
    input  logic                  m_rready,
    input  logic                  ar_stall,
    input  logic                  r_stall
);

    axil_rd_pkg::addr_t addr_q;
    logic               have_addr;
    logic               ar_done;
    logic               r_done;
    logic               rst_q;
    logic               ar_stall_q;
    logic               r_stall_q;

    initial begin
        m_arready = 1'b0;
        m_rvalid  = 1'b0;
        m_r       = '0;
        have_addr = 1'b0;
    end

    // handshakes and controls are sampled at the rising edge, outputs move at the falling edge
    always @(posedge clk) begin
        ar_done    <= m_arvalid && m_arready;
        r_done     <= m_rvalid && m_rready;
        rst_q      <= rst;
        ar_stall_q <= ar_stall;
        r_stall_q  <= r_stall;
        if (m_arvalid && m_arready) begin
            addr_q <= m_ar.addr;
        end
    end

    always @(negedge clk) begin
        if (rst_q) begin
            m_arready = 1'b0;
            m_rvalid  = 1'b0;
            have_addr = 1'b0;
        end else begin
            if (r_done) begin
                m_rvalid = 1'b0;
            end
            if (ar_done) begin
                have_addr = 1'b1;
            end
            if (have_addr && !m_rvalid && !r_stall_q) begin
                m_rvalid  = 1'b1;
                m_r.data  = addr_q ^ 32'h5a5a_0000;
                m_r.resp  = (addr_q >= 32'h100 && addr_q <= 32'h10f) ?
                            axil_rd_pkg::resp_slverr : axil_rd_pkg::resp_okay;
                have_addr = 1'b0;
            end
            // one address at a time, taken only while no read is open
            m_arready = !have_addr && !m_rvalid && !ar_done && !ar_stall_q;
        end
    end

endmodule

//--- tests/rd_checker.sv
// R channel checker: reference model of the beat rule, beat by beat comparison, Lite AR prot check
module rd_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  axil_rd_pkg::axi_ar_t  s_ar,
    input  logic                  s_arvalid,
    input  logic                  s_arready,
    input  axil_rd_pkg::axi_r_t   s_r,
    input  logic                  s_rvalid,
    input  logic                  s_rready,
    input  axil_rd_pkg::axil_ar_t m_ar,
    input  logic                  m_arvalid,
    input  logic                  m_arready,
    output int                    error_count,
    output int                    beat_count,
    output int                    burst_count
);

    axil_rd_pkg::axi_ar_t ar_q[$];
    int                   beat_idx;
    logic                 ar_seen;

    // beat n of a burst; lanes marks the Lite words that carry data
    function automatic axil_rd_pkg::axi_r_t expected_beat(input axil_rd_pkg::axi_ar_t ar,
                                                          input int n,
                                                          output logic [1:0] lanes);
        axil_rd_pkg::axi_r_t want;
        axil_rd_pkg::addr_t  step;
        axil_rd_pkg::addr_t  beat_addr;
        axil_rd_pkg::addr_t  word_addr;
        int                  l;
        step      = axil_rd_pkg::addr_t'(1) << ar.size;
        beat_addr = ar.addr;
        if (n > 0) begin
            beat_addr = (ar.addr & ~(step - 1)) + step * n;
        end
        if (ar.size == 3'd3) begin
            lanes = beat_addr[2] ? 2'b10 : 2'b11;
        end else begin
            lanes = beat_addr[2] ? 2'b10 : 2'b01;
        end
        want.id   = ar.id;
        want.data = '0;
        want.resp = axil_rd_pkg::resp_okay;
        want.last = (n == int'(ar.len));
        for (l = 0; l < 2; l++) begin
            if (lanes[l]) begin
                word_addr = {beat_addr[31:3], l[0], 2'b00};
                want.data[l*32 +: 32] = word_addr ^ 32'h5a5a_0000;
                if (word_addr >= 32'h100 && word_addr <= 32'h10f) begin
                    want.resp = axil_rd_pkg::resp_slverr;
                end
            end
        end
        return want;
    endfunction

    task automatic report_mismatch(input string what, input logic [63:0] got,
                                   input logic [63:0] want);
        $display("[FAIL] %0t: beat %0d %s is %h, expected %h", $time, beat_idx, what, got, want);
        error_count++;
    endtask

    always @(posedge clk) begin
        axil_rd_pkg::axi_r_t want;
        logic [1:0]          lanes;
        logic [63:0]         mask;
        if (rst) begin
            ar_seen  = 1'b0;
            beat_idx = 0;
        end else begin
            if (!ar_seen && (s_rvalid || m_arvalid)) begin
                $display("[FAIL] %0t: valid raised before the first AR handshake", $time);
                error_count++;
            end
            if (s_rvalid && s_rready) begin
                beat_count++;
                if (ar_q.size() == 0) begin
                    $display("R beat at time %0t arrived with no burst outstanding", $time);
                    error_count++;
                end else begin
                    want = expected_beat(ar_q[0], beat_idx, lanes);
                    mask = {{32{lanes[1]}}, {32{lanes[0]}}};
                    if (s_r.id != want.id) report_mismatch("id", s_r.id, want.id);
                    if (s_r.resp != want.resp) report_mismatch("resp", s_r.resp, want.resp);
                    if (s_r.last != want.last) report_mismatch("last", s_r.last, want.last);
                    if ((s_r.data & mask) != want.data) begin
                        report_mismatch("data", s_r.data & mask, want.data);
                    end
                    if (want.last) begin
                        void'(ar_q.pop_front());
                        burst_count++;
                        beat_idx = 0;
                    end else begin
                        beat_idx++;
                    end
                end
            end
            // every Lite read carries the protection of the burst it serves
            if (m_arvalid && m_arready) begin
                if (ar_q.size() == 0) begin
                    $display("Lite read address at time %0t issued with no burst outstanding",
                             $time);
                    error_count++;
                end else if (m_ar.prot != ar_q[$].prot) begin
                    report_mismatch("prot", m_ar.prot, ar_q[$].prot);
                end
            end
            if (s_arvalid && s_arready) begin
                ar_q.push_back(s_ar);
                ar_seen = 1'b1;
            end
        end
    end

endmodule

//--- tests/tb_axi_axil_rd_bridge.sv
// testbench top: clock, reset, Lite slave model, AXI burst stimulus and result summary
module tb_axi_axil_rd_bridge;

    logic clk, rst, s_arvalid, s_arready, s_rvalid, s_rready;
    logic m_arvalid, m_arready, m_rvalid, m_rready, ar_stall, r_stall, stall_en, timed_out;
    axil_rd_pkg::axi_ar_t  s_ar;
    axil_rd_pkg::axi_r_t   s_r;
    axil_rd_pkg::axil_ar_t m_ar;
    axil_rd_pkg::axil_r_t  m_r;
    int          error_count, beat_count, burst_count, bursts_sent, errors_before, tests_run;
    logic [31:0] stim_rng, delay_rng;

    axi_axil_rd_bridge axi_axil_rd_bridge_inst (.*);

    axil_slave_model axil_slave_model_inst (.*);

    rd_checker rd_checker_inst (.*);

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    always #2 clk = ~clk;

    // s_rready and slave stalls, each cycle, once stalls are switched on
    always @(negedge clk) begin
        delay_rng = xorshift32(delay_rng);
        s_rready  = !stall_en || (|delay_rng[1:0]);
        ar_stall  = stall_en && (&delay_rng[9:8]);
        r_stall   = stall_en && delay_rng[16];
    end

    task automatic wait_cycles_until_ready(input string what);
        int cycles;
        cycles = 0;
        while (!s_arready && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2000) begin
                $display("timeout: s_arready stayed low while %s", what);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic run_burst(input logic [3:0] id, input logic [31:0] addr,
                             input logic [7:0] len, input logic [2:0] size);
        int cycles;
        s_ar      = '{id: id, addr: addr, len: len, size: size, prot: id[2:0]};
        s_arvalid = 1'b1;
        wait_cycles_until_ready("offering a burst");
        @(negedge clk);
        s_arvalid = 1'b0;
        bursts_sent++;
        cycles = 0;
        while (burst_count < bursts_sent && !timed_out) begin
            @(negedge clk);
            cycles++;
            if (cycles > 2000) begin
                $display("timeout: burst at address %h never delivered its last beat", addr);
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic finish_test(input string name);
        int errs;
        errs          = error_count - errors_before;
        errors_before = error_count;
        tests_run++;
        if (timed_out) begin
            $display("test %s: stopped by a timeout", name);
        end else begin
            $display("test %s: %0d errors", name, errs);
        end
    endtask

    initial begin
        int n;
        clk = 1'b0;
        rst = 1'b1;
        s_ar = '0;
        s_arvalid = 1'b0;
        s_rready = 1'b0;
        stall_en = 1'b0;
        timed_out = 1'b0;
        stim_rng = 32'h7ede0554;
        delay_rng = {stim_rng[15:0], stim_rng[31:16]};
        repeat (3) @(negedge clk);
        rst = 1'b0;
        // checker flags any valid before the first burst
        wait_cycles_until_ready("idle after reset");
        repeat (4) @(negedge clk);
        finish_test("reset_idle");
        run_burst(4'h3, 32'h0000_0040, 8'd3, 3'd3);
        finish_test("full_aligned");
        run_burst(4'h5, 32'h0000_0084, 8'd5, 3'd2);
        finish_test("narrow");
        run_burst(4'h9, 32'h0000_00c4, 8'd2, 3'd3);
        finish_test("offset_start");
        run_burst(4'hc, 32'h0000_00f8, 8'd3, 3'd3);
        run_burst(4'h1, 32'h0000_0108, 8'd3, 3'd2);
        finish_test("error_window");
        @(posedge clk);
        stall_en = 1'b1;
        @(negedge clk);
        for (n = 0; n < 40; n++) begin
            stim_rng = xorshift32(stim_rng);
            run_burst(stim_rng[3:0], {23'd0, stim_rng[12:4]}, {5'd0, stim_rng[15:13]},
                      {1'b0, stim_rng[17:16]});
        end
        finish_test("random_bursts");
        $display("%0d tests, %0d bursts, %0d beats, %0d errors", tests_run, burst_count,
                 beat_count, error_count);
        if (timed_out || error_count != 0) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    end

endmodule

//--- build.f
hdl/axil_rd_pkg.sv
hdl/rd_burst_ctrl.sv
hdl/rd_lane_merge.sv
hdl/axi_axil_rd_bridge.sv
tests/axil_slave_model.sv
tests/rd_checker.sv
tests/tb_axi_axil_rd_bridge.sv

//--- Bender.yml
package:
  name: axi_axil_rd_bridge

sources:
  - hdl/axil_rd_pkg.sv
  - hdl/rd_burst_ctrl.sv
  - hdl/rd_lane_merge.sv
  - hdl/axi_axil_rd_bridge.sv
  - target: test
    files:
      - tests/axil_slave_model.sv
      - tests/rd_checker.sv
      - tests/tb_axi_axil_rd_bridge.sv
